/* Makefile */
# Verilator build for the convolution accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_conv_acc
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= === PASS ===

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	$(EXE) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
src/cnn_acc_pkg.sv
src/glb_ram.sv
src/glb_buf.sv
src/axil_regs.sv
src/pe_column.sv
src/conv_acc_top.sv
testbench/tb_clk_gen.sv
testbench/tb_conv_acc.sv

/* src/axil_regs.sv */
`timescale 1ns/1ps

module axil_regs
    import cnn_acc_pkg::*;
(
    input  logic                      bus_clk,
    input  logic                      rstn,
    input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [WORD_WIDTH-1:0]     wdata,
    input  logic [WORD_WIDTH/8-1:0]   wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [WORD_WIDTH-1:0]     rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic                      busy,
    input  logic                      done,
    input  len_t                      fill,
    input  psum_t [NUM_COL-1:0]       results,
    output buf_wr_t                   wr,
    output run_cmd_t                  cmd,
    output logic                      irq_done
);

    logic wr_acc;
    logic rd_acc;
    logic wr_block;
    logic wr_do;
    logic aw_ifmap;
    logic aw_fltr;
    logic aw_psum;
    logic aw_ctrl;
    logic aw_len;
    logic aw_ksize;
    logic ar_psum;

    len_t                  len_q;
    tag_t                  ksize_q;
    logic                  done_q;
    logic                  irq_q;
    logic [WORD_WIDTH-1:0] rd_mux;

    assign wr_acc = awready && awvalid && wvalid;
    assign rd_acc = arready && arvalid;

    ////////////////////////////////////////////////////////////////////////////
    // Write address decode

    assign aw_ifmap = awaddr[AXI_ADDR_WIDTH-1:WIN_LSB] == IFMAP_BASE[AXI_ADDR_WIDTH-1:WIN_LSB];
    assign aw_fltr  = awaddr[AXI_ADDR_WIDTH-1:WIN_LSB] == FLTR_BASE[AXI_ADDR_WIDTH-1:WIN_LSB];
    assign aw_psum  = awaddr[AXI_ADDR_WIDTH-1:PSUM_LSB] == PSUM_BASE[AXI_ADDR_WIDTH-1:PSUM_LSB];
    assign aw_ctrl  = (awaddr == REG_CTRL);
    assign aw_len   = (awaddr == REG_LENGTH);
    assign aw_ksize = (awaddr == REG_KSIZE);

    // Buffers and run setup are frozen during a run
    assign wr_block = busy && (aw_ifmap || aw_fltr || aw_psum || aw_len || aw_ksize);
    assign wr_do    = wr_acc && !wr_block && (|wstrb);

    always_comb begin
        wr.ifmap = wr_do && aw_ifmap;
        wr.fltr  = wr_do && aw_fltr;
        wr.psum  = wr_do && aw_psum;
        // Psum window holds one word per column
        wr.addr  = aw_psum ? buf_addr_t'(awaddr[PSUM_LSB-1:2]) : awaddr[WIN_LSB-1:2];
        wr.data  = wdata;
    end

    assign cmd.start  = wr_do && aw_ctrl && wdata[0] && !busy;
    assign cmd.length = len_q;
    assign cmd.ksize  = ksize_q;
    assign irq_done   = irq_q;

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes with one transfer in flight per direction

    always_ff @(posedge bus_clk or negedge rstn) begin
        if (!rstn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            if (wr_acc) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            arready <= arvalid && !rvalid && !arready;
            if (rd_acc) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (wr_acc) begin
            bresp <= wr_block ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_acc) begin
            rdata <= rd_mux;
        end
    end

    assign rresp = RESP_OKAY;

    // Control registers
    always_ff @(posedge bus_clk or negedge rstn) begin
        if (!rstn) begin
            len_q   <= '0;
            ksize_q <= '0;
            done_q  <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            if (wr_do && aw_len) begin
                len_q <= wdata[LEN_WIDTH-1:0];
            end
            if (wr_do && aw_ksize) begin
                ksize_q <= wdata[TAG_WIDTH-1:0];
            end
            if (done) begin
                done_q <= 1'b1;
                irq_q  <= 1'b1;
            end else if (wr_do && aw_ctrl) begin
                // New run also clears the old done
                if (wdata[1] || cmd.start) begin
                    done_q <= 1'b0;
                end
                irq_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data mux

    assign ar_psum = araddr[AXI_ADDR_WIDTH-1:PSUM_LSB] == PSUM_BASE[AXI_ADDR_WIDTH-1:PSUM_LSB];

    always_comb begin
        rd_mux = '0;
        if (ar_psum) begin
            rd_mux = results[araddr[PSUM_LSB-1:2]];
        end else begin
            case (araddr)
                REG_CTRL:   rd_mux = {{(WORD_WIDTH - 2){1'b0}}, done_q, busy};
                REG_LENGTH: rd_mux = WORD_WIDTH'(len_q);
                REG_KSIZE:  rd_mux = WORD_WIDTH'(ksize_q);
                REG_FILL:   rd_mux = WORD_WIDTH'(fill);
                default:    rd_mux = '0;
            endcase
        end
    end

endmodule

/* src/cnn_acc_pkg.sv */
package cnn_acc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int DATA_WIDTH     = 16;
    localparam int PSUM_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int NUM_COL        = 8;
    localparam int BUFFER_SIZE    = 512;
    localparam int ID_WIDTH       = 4;
    localparam int TAG_WIDTH      = 8;
    localparam int AXI_ADDR_WIDTH = 16;

    localparam int COL_IDX_WIDTH  = $clog2(NUM_COL);
    localparam int BUF_ADDR_WIDTH = $clog2(BUFFER_SIZE);
    // One extra bit so a full buffer count fits
    localparam int LEN_WIDTH      = BUF_ADDR_WIDTH + 1;

    // Low address bit of the buffer windows and of the psum window
    localparam int WIN_LSB        = BUF_ADDR_WIDTH + 2;
    localparam int PSUM_LSB       = COL_IDX_WIDTH + 2;

    ////////////////////////////////////////////////////////////////////////////
    // Register map

    localparam logic [AXI_ADDR_WIDTH-1:0] REG_CTRL   = 16'h0000;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_LENGTH = 16'h0004;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_KSIZE  = 16'h0008;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_FILL   = 16'h000C;
    localparam logic [AXI_ADDR_WIDTH-1:0] PSUM_BASE  = 16'h0100;
    localparam logic [AXI_ADDR_WIDTH-1:0] IFMAP_BASE = 16'h0800;
    localparam logic [AXI_ADDR_WIDTH-1:0] FLTR_BASE  = 16'h1000;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;
    typedef logic [ID_WIDTH-1:0]          col_id_t;
    typedef logic [TAG_WIDTH-1:0]         tag_t;
    typedef logic [BUF_ADDR_WIDTH-1:0]    buf_addr_t;
    typedef logic [LEN_WIDTH-1:0]         len_t;

    typedef struct packed {
        logic                  ifmap;
        logic                  fltr;
        logic                  psum;
        buf_addr_t             addr;
        logic [WORD_WIDTH-1:0] data;
    } buf_wr_t;

    typedef struct packed {
        logic start;
        len_t length;
        tag_t ksize;
    } run_cmd_t;

    // Multicast word seen by every PE column
    typedef struct packed {
        logic    valid;
        col_id_t x_id;
        tag_t    x_tag;
        data_t   ifmap;
        data_t   fltr;
    } glb_bus_t;

    typedef struct packed {
        logic                     valid;
        logic [COL_IDX_WIDTH-1:0] col;
        psum_t                    value;
    } psum_load_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PRELOAD,
        SEQ_STREAM,
        SEQ_DRAIN
    } seq_state_t;

endpackage

/* src/conv_acc_top.sv */
`timescale 1ns/1ps

module conv_acc_top
    import cnn_acc_pkg::*;
(
    input  logic                      bus_clk,
    input  logic                      rstn,
    input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [WORD_WIDTH-1:0]     wdata,
    input  logic [WORD_WIDTH/8-1:0]   wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [WORD_WIDTH-1:0]     rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output logic                      irq_done
);

    buf_wr_t             wr;
    run_cmd_t            cmd;
    logic                busy;
    logic                done;
    len_t                fill;
    psum_load_t          pload;
    glb_bus_t            gbus;
    psum_t [NUM_COL-1:0] results;

    // Host side
    axil_regs axil_regs_i (
        .bus_clk  (bus_clk),
        .rstn     (rstn),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .busy     (busy),
        .done     (done),
        .fill     (fill),
        .results  (results),
        .wr       (wr),
        .cmd      (cmd),
        .irq_done (irq_done)
    );

    glb_buf glb_buf_i (
        .bus_clk (bus_clk),
        .rstn    (rstn),
        .wr      (wr),
        .cmd     (cmd),
        .busy    (busy),
        .done    (done),
        .fill    (fill),
        .pload   (pload),
        .gbus    (gbus)
    );

    pe_column pe_column_i (
        .bus_clk (bus_clk),
        .rstn    (rstn),
        .pload   (pload),
        .gbus    (gbus),
        .results (results)
    );

endmodule

/* src/glb_buf.sv */
`timescale 1ns/1ps

module glb_buf
    import cnn_acc_pkg::*;
(
    input  logic       bus_clk,
    input  logic       rstn,
    input  buf_wr_t    wr,
    input  run_cmd_t   cmd,
    output logic       busy,
    output logic       done,
    output len_t       fill,
    output psum_load_t pload,
    output glb_bus_t   gbus
);

    seq_state_t state;
    len_t       len_q;
    tag_t       ksize_q;
    len_t       cnt;
    tag_t       tag;
    logic       start_ok;
    buf_addr_t  rd_addr;
    buf_addr_t  fltr_addr;

    logic                     pl_valid_q;
    logic [COL_IDX_WIDTH-1:0] pl_col_q;
    logic                     bus_valid_q;
    tag_t                     bus_tag_q;

    logic [WORD_WIDTH-1:0] ifmap_rdata;
    logic [WORD_WIDTH-1:0] fltr_rdata;
    logic [WORD_WIDTH-1:0] psum_rdata;

    assign start_ok  = cmd.start && (state == SEQ_IDLE);
    assign busy      = (state != SEQ_IDLE);
    assign done      = (state == SEQ_DRAIN) && (cnt == len_t'(1));
    assign rd_addr   = buf_addr_t'(cnt);
    assign fltr_addr = buf_addr_t'(tag);

    ////////////////////////////////////////////////////////////////////////////
    // Run sequencer

    always_ff @(posedge bus_clk or negedge rstn) begin
        if (!rstn) begin
            state   <= SEQ_IDLE;
            len_q   <= '0;
            ksize_q <= '0;
            cnt     <= '0;
            tag     <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start_ok) begin
                        state   <= SEQ_PRELOAD;
                        len_q   <= cmd.length;
                        ksize_q <= (cmd.ksize == '0) ? tag_t'(1) : cmd.ksize;
                        cnt     <= '0;
                    end
                end
                SEQ_PRELOAD: begin
                    tag <= '0;
                    if (cnt == len_t'(NUM_COL - 1)) begin
                        cnt   <= '0;
                        // Empty run goes straight to drain
                        state <= (len_q == '0) ? SEQ_DRAIN : SEQ_STREAM;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SEQ_STREAM: begin
                    // Kernel tap wraps at ksize
                    tag <= (tag == ksize_q - 1'b1) ? '0 : tag + 1'b1;
                    if (cnt == len_q - 1'b1) begin
                        cnt   <= '0;
                        state <= SEQ_DRAIN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SEQ_DRAIN: begin
                    // RAM latency plus PE register
                    if (cnt == len_t'(1)) begin
                        cnt   <= '0;
                        state <= SEQ_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Ifmap writes since the last run
    always_ff @(posedge bus_clk or negedge rstn) begin
        if (!rstn) begin
            fill <= '0;
        end else if (start_ok) begin
            fill <= '0;
        end else if (wr.ifmap && (fill != '1)) begin
            fill <= fill + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Line up valid and tag with the RAM outputs

    always_ff @(posedge bus_clk or negedge rstn) begin
        if (!rstn) begin
            pl_valid_q  <= 1'b0;
            bus_valid_q <= 1'b0;
        end else begin
            pl_valid_q  <= (state == SEQ_PRELOAD);
            bus_valid_q <= (state == SEQ_STREAM);
        end
    end

    always_ff @(posedge bus_clk) begin
        pl_col_q  <= cnt[COL_IDX_WIDTH-1:0];
        bus_tag_q <= tag;
    end

    always_comb begin
        pload.valid = pl_valid_q;
        pload.col   = pl_col_q;
        pload.value = psum_t'(psum_rdata);

        gbus.valid  = bus_valid_q;
        gbus.x_id   = ifmap_rdata[DATA_WIDTH +: ID_WIDTH];
        gbus.x_tag  = bus_tag_q;
        gbus.ifmap  = ifmap_rdata[DATA_WIDTH-1:0];
        gbus.fltr   = fltr_rdata[DATA_WIDTH-1:0];
    end

    glb_ram ifmap_ram_i (
        .bus_clk (bus_clk),
        .we      (wr.ifmap),
        .waddr   (wr.addr),
        .wdata   (wr.data),
        .re      (state == SEQ_STREAM),
        .raddr   (rd_addr),
        .rdata   (ifmap_rdata)
    );

    glb_ram fltr_ram_i (
        .bus_clk (bus_clk),
        .we      (wr.fltr),
        .waddr   (wr.addr),
        .wdata   (wr.data),
        .re      (state == SEQ_STREAM),
        .raddr   (fltr_addr),
        .rdata   (fltr_rdata)
    );

    glb_ram psum_ram_i (
        .bus_clk (bus_clk),
        .we      (wr.psum),
        .waddr   (wr.addr),
        .wdata   (wr.data),
        .re      (state == SEQ_PRELOAD),
        .raddr   (rd_addr),
        .rdata   (psum_rdata)
    );

endmodule

/* src/glb_ram.sv */
`timescale 1ns/1ps

module glb_ram
    import cnn_acc_pkg::*;
(
    input  logic                  bus_clk,
    input  logic                  we,
    input  buf_addr_t             waddr,
    input  logic [WORD_WIDTH-1:0] wdata,
    input  logic                  re,
    input  buf_addr_t             raddr,
    output logic [WORD_WIDTH-1:0] rdata
);

    logic [WORD_WIDTH-1:0] mem [BUFFER_SIZE];

    // Write port
    always_ff @(posedge bus_clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read that holds its value while re is low
    always_ff @(posedge bus_clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* src/pe_column.sv */
`timescale 1ns/1ps

module pe_column
    import cnn_acc_pkg::*;
(
    input  logic                bus_clk,
    input  logic                rstn,
    input  psum_load_t          pload,
    input  glb_bus_t            gbus,
    output psum_t [NUM_COL-1:0] results
);

    psum_t              prod;
    logic [NUM_COL-1:0] load_hit;
    logic [NUM_COL-1:0] acc_hit;

    // Signed 16x16 product that wraps at 32 bits
    assign prod = psum_t'(gbus.ifmap) * psum_t'(gbus.fltr);

    ////////////////////////////////////////////////////////////////////////////
    // Column match

    always_comb begin
        for (int c = 0; c < NUM_COL; c++) begin
            load_hit[c] = pload.valid && (pload.col == COL_IDX_WIDTH'(c));
            // Ids with the extension bit set fall through here
            acc_hit[c]  = gbus.valid && (gbus.x_id == col_id_t'(c));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Accumulators

    always_ff @(posedge bus_clk or negedge rstn) begin
        if (!rstn) begin
            results <= '0;
        end else begin
            for (int c = 0; c < NUM_COL; c++) begin
                if (load_hit[c]) begin
                    results[c] <= pload.value;
                end else if (acc_hit[c]) begin
                    results[c] <= results[c] + prod;
                end
            end
        end
    end

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic bus_clk,
    output logic rstn
);

    // 10 ns period
    initial begin
        bus_clk = 1'b0;
        forever #5 bus_clk = ~bus_clk;
    end

    // Reset held low for 8 cycles
    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge bus_clk);
        rstn <= 1'b1;
    end

endmodule

/* testbench/tb_conv_acc.sv */
`timescale 1ns/1ps

module tb_conv_acc
    import cnn_acc_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam int POLL_LIMIT = 100;

    logic                      bus_clk;
    logic                      rstn;
    logic [AXI_ADDR_WIDTH-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [WORD_WIDTH-1:0]     wdata;
    logic [WORD_WIDTH/8-1:0]   wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [AXI_ADDR_WIDTH-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [WORD_WIDTH-1:0]     rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;
    logic                      irq_done;

    // Model of the buffer contents
    data_t   sample_m [BUFFER_SIZE];
    col_id_t id_m     [BUFFER_SIZE];
    data_t   weight_m [1 << TAG_WIDTH];
    psum_t   psum_m   [NUM_COL];
    int      len_m;
    int      ksize_m;
    int      fill_m;

    logic [31:0] seed;
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];
    string       what_q [$];

    tb_clk_gen clk_gen_i (
        .bus_clk (bus_clk),
        .rstn    (rstn)
    );

    conv_acc_top conv_acc_top_i (
        .bus_clk  (bus_clk),
        .rstn     (rstn),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .irq_done (irq_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers, reference model and checks

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        seed = xorshift32(seed);
        return seed;
    endfunction

    // Initial psum plus data times weight of every entry with this id
    function automatic psum_t conv_ref(input int col);
        psum_t acc;
        int    k;
        int    prod;
        acc = psum_m[col];
        k   = (ksize_m == 0) ? 1 : ksize_m;
        for (int i = 0; i < len_m; i++) begin
            if (int'(id_m[i]) == col) begin
                prod = int'(sample_m[i]) * int'(weight_m[i % k]);
                acc  = acc + prod;
            end
        end
        return acc;
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    endtask

    task automatic push_check(input logic [31:0] got, input logic [31:0] exp, input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
    endtask

    // Compare process
    always @(negedge bus_clk) begin
        while (got_q.size() > 0) begin
            check_val(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-Lite master

    task automatic axi_write(
        input  logic [AXI_ADDR_WIDTH-1:0] addr,
        input  logic [WORD_WIDTH-1:0]     data,
        output logic [1:0]                resp
    );
        int n;
        int stall;
        @(posedge bus_clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        @(negedge bus_clk);
        while (!awready && !wready) begin
            if (n == WAIT_LIMIT) timeout_fail("awready and wready");
            n++;
            @(negedge bus_clk);
        end
        push_check(32'({awready, wready}), 32'h3, "awready and wready together");
        @(posedge bus_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(negedge bus_clk);
        while (!bvalid) begin
            if (n == WAIT_LIMIT) timeout_fail("bvalid");
            n++;
            @(negedge bus_clk);
        end
        resp  = bresp;
        // Hold bready low for a random stretch
        stall = int'(rand32() & 32'h3);
        repeat (stall) @(posedge bus_clk);
        @(posedge bus_clk);
        bready <= 1'b1;
        @(posedge bus_clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(
        input  logic [AXI_ADDR_WIDTH-1:0] addr,
        output logic [WORD_WIDTH-1:0]     data,
        output logic [1:0]                resp
    );
        int n;
        int stall;
        @(posedge bus_clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(negedge bus_clk);
        while (!arready) begin
            if (n == WAIT_LIMIT) timeout_fail("arready");
            n++;
            @(negedge bus_clk);
        end
        @(posedge bus_clk);
        arvalid <= 1'b0;
        n = 0;
        @(negedge bus_clk);
        while (!rvalid) begin
            if (n == WAIT_LIMIT) timeout_fail("rvalid");
            n++;
            @(negedge bus_clk);
        end
        data  = rdata;
        resp  = rresp;
        stall = int'(rand32() & 32'h3);
        repeat (stall) @(posedge bus_clk);
        @(posedge bus_clk);
        rready <= 1'b1;
        @(posedge bus_clk);
        rready <= 1'b0;
    endtask

    task automatic write_expect(
        input logic [AXI_ADDR_WIDTH-1:0] addr,
        input logic [WORD_WIDTH-1:0]     data,
        input logic [1:0]                exp_resp
    );
        logic [1:0] resp;
        axi_write(addr, data, resp);
        push_check(32'(resp), 32'(exp_resp), "write response");
    endtask

    task automatic read_expect(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] v;
        logic [1:0]  resp;
        axi_read(addr, v, resp);
        push_check(32'(resp), 32'(RESP_OKAY), "read response");
        push_check(v, exp, what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run helpers

    // Fresh filters, ifmap entries and initial psums for one run
    task automatic load_run(input int len, input int ksize);
        logic [31:0] r;
        int          k;
        len_m   = len;
        ksize_m = ksize;
        k       = (ksize == 0) ? 1 : ksize;
        for (int t = 0; t < k; t++) begin
            r = rand32();
            weight_m[t] = r[15:0];
            write_expect(FLTR_BASE + 16'(t * 4), {16'h0, weight_m[t]}, RESP_OKAY);
        end
        for (int i = 0; i < len; i++) begin
            r = rand32();
            sample_m[i] = r[15:0];
            // Ids cover 0 to 15 and the upper half hits no column
            id_m[i] = r[19:16];
            write_expect(IFMAP_BASE + 16'(i * 4), {12'h0, id_m[i], sample_m[i]}, RESP_OKAY);
            fill_m++;
        end
        for (int c = 0; c < NUM_COL; c++) begin
            psum_m[c] = rand32();
            write_expect(PSUM_BASE + 16'(c * 4), psum_m[c], RESP_OKAY);
        end
        write_expect(REG_LENGTH, 32'(len), RESP_OKAY);
        write_expect(REG_KSIZE, 32'(ksize), RESP_OKAY);
        read_expect(REG_FILL, 32'(fill_m), "REG_FILL after ifmap writes");
    endtask

    task automatic start_run();
        write_expect(REG_CTRL, 32'h1, RESP_OKAY);
        fill_m = 0;
    endtask

    task automatic wait_done();
        logic [31:0] v;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        axi_read(REG_CTRL, v, resp);
        while (!v[1]) begin
            if (polls == POLL_LIMIT) timeout_fail("the done bit in REG_CTRL");
            polls++;
            axi_read(REG_CTRL, v, resp);
        end
        push_check(v, 32'h2, "REG_CTRL at end of run");
        @(negedge bus_clk);
        push_check(32'(irq_done), 32'h1, "irq_done after run");
    endtask

    task automatic check_results();
        for (int c = 0; c < NUM_COL; c++) begin
            read_expect(PSUM_BASE + 16'(c * 4), conv_ref(c), $sformatf("result of column %0d", c));
        end
    endtask

    task automatic clear_done();
        write_expect(REG_CTRL, 32'h2, RESP_OKAY);
        @(negedge bus_clk);
        push_check(32'(irq_done), 32'h0, "irq_done after clear");
        read_expect(REG_CTRL, 32'h0, "REG_CTRL after clear");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int          n;
        int          len;
        int          ks;
        logic [31:0] r;
        seed    = 32'h2ec7_0523;
        fill_m  = 0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;

        n = 0;
        @(negedge bus_clk);
        while (!rstn) begin
            if (n == WAIT_LIMIT) timeout_fail("reset release");
            n++;
            @(negedge bus_clk);
        end

        // State after reset
        read_expect(REG_CTRL, 32'h0, "REG_CTRL after reset");
        read_expect(REG_FILL, 32'h0, "REG_FILL after reset");
        @(negedge bus_clk);
        push_check(32'(irq_done), 32'h0, "irq_done after reset");

        // First run
        r   = rand32();
        len = 16 + int'(r[4:0]);
        ks  = 1 + int'(r[10:8]);
        load_run(len, ks);
        start_run();
        wait_done();
        check_results();
        clear_done();

        // Second run with other ksize and length
        r   = rand32();
        len = 48 + int'(r[5:0]);
        ks  = ks + 1 + int'(r[10:8]);
        load_run(len, ks);
        start_run();
        wait_done();
        check_results();
        clear_done();

        // Third run where writes while busy are refused
        r   = rand32();
        len = 56 + int'(r[2:0]);
        ks  = int'(r[9:8]);
        load_run(len, ks);
        start_run();
        read_expect(REG_CTRL, 32'h1, "REG_CTRL busy during run");
        write_expect(IFMAP_BASE, 32'h000F_7FFF, RESP_SLVERR);
        write_expect(FLTR_BASE, 32'h0000_1234, RESP_SLVERR);
        write_expect(PSUM_BASE, 32'h5555_AAAA, RESP_SLVERR);
        write_expect(REG_KSIZE, 32'h0000_0007, RESP_SLVERR);
        wait_done();
        check_results();
        read_expect(REG_FILL, 32'h0, "REG_FILL after blocked ifmap write");
        read_expect(REG_KSIZE, 32'(ks), "REG_KSIZE after blocked write");
        clear_done();

        // Let the compare process catch up
        n = 0;
        while ((got_q.size() != 0) && (n < WAIT_LIMIT)) begin
            @(negedge bus_clk);
            n++;
        end
        if (got_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Compare queue still holds %0d entries", got_q.size());
            $display("=== FAIL ===");
            $fatal(1, "compare queue not drained");
        end
    end

endmodule
